// File: Makefile
SIM      = verilator
TOP      = frontend_tb
FILELIST = all.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)
RUNFLAGS = +verilator+error+limit+1000
OBJ_DIR  = obj_dir
LOG      = sim.log
SOURCES  = $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/mem_arbiter.sv
hdl/icache.sv
hdl/data_load_port.sv
hdl/fetch_stage.sv
hdl/frontend_top.sv
tests/mem_model.sv
tests/frontend_props.sv
tests/frontend_tb.sv

// File: hdl/data_load_port.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

// one uncached double word load at a time
module data_load_port import fetch_pkg::*; (
	input                    clock,
	input                    reset,
	input                    load_req,    // pulse, ignored while busy
	input  [`XLEN-1:0]       load_addr,
	input  mem_tag_t         dp_response, // grant tag, via the arbiter
	input  mem_block_t       mem_data,
	input  mem_tag_t         mem_tag,

	output bus_cmd_t         dp_command,
	output logic [`XLEN-1:0] dp_addr,
	output logic             load_busy,
	output logic [63:0]      load_data,
	output logic             load_done
);

	logic             busy;    // request latched
	logic             granted; // memory took it, waiting on the reply
	logic             done;
	mem_tag_t         tag_q;
	logic [`XLEN-1:0] addr_q;
	logic [63:0]      data_q;
	logic             grant;
	logic             reply;

	// request stays up every cycle until memory hands back a tag
	assign dp_command = (busy && !granted) ? bus_load : bus_none;
	assign dp_addr    = {addr_q[`XLEN-1:`BLOCK_OFF_W], {`BLOCK_OFF_W{1'b0}}};

	assign grant = (dp_command == bus_load) && (dp_response != '0);
	assign reply = granted && (mem_tag == tag_q);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			granted <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= reply;               // one cycle pulse
			if (reply) begin
				busy    <= 1'b0;         // drops with the done pulse
				granted <= 1'b0;
			end else if (grant) begin
				granted <= 1'b1;
			end else if (load_req && !busy) begin
				busy <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load_req && !busy)
			addr_q <= load_addr;
		if (grant)
			tag_q <= dp_response;
		if (reply)
			data_q <= mem_data.dword; // whole block as one double word
	end

	assign load_busy = busy;
	assign load_done = done;
	assign load_data = data_q;

endmodule

// File: hdl/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address and data path widths
`define XLEN 32         // byte address width
`define MEM_TAG_W 4     // memory reply tag, zero means no tag

// memory block geometry
`define BLOCK_OFF_W 3   // 8 bytes per memory block

// instruction cache geometry
`define ICACHE_LINES 32 // one block per line
`define ICACHE_IDX_W 5  // log2 of ICACHE_LINES

// shown on the fetch output whenever no instruction is valid
// addi x0, x0, 0
`define NOP_INST 32'h00000013

`endif

// File: hdl/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// memory bus types
	////////////////////////////////////////////////////////////////////////////

	// command codes of the tagged memory bus
	typedef enum logic [1:0] {
		bus_none  = 2'h0, // idle
		bus_load  = 2'h1, // read one block
		bus_store = 2'h2  // reserved
	} bus_cmd_t;

	typedef logic [`MEM_TAG_W-1:0] mem_tag_t; // 0 = refused / no reply

	// one 64 bit memory word
	// load port reads it whole, icache picks one of the two instructions
	typedef union packed {
		logic [63:0]      dword; // double word view
		logic [1:0][31:0] inst;  // inst[0] sits at the lower address
	} mem_block_t;

endpackage

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_stage import fetch_pkg::*; (
	input                    clock,
	input                    reset,
	input                    hold,        // back end stall, freezes the outputs
	input                    redirect,    // load redirect_pc at the next edge
	input  [`XLEN-1:0]       redirect_pc,
	input  [31:0]            icache_inst,
	input                    icache_hit,

	output logic [`XLEN-1:0] fetch_pc,    // to icache
	output logic [`XLEN-1:0] inst_pc,
	output logic [31:0]      inst,
	output logic             inst_valid
);

	logic [`XLEN-1:0] pc;

	// copy of what was shown last cycle, replayed while hold is up
	logic [`XLEN-1:0] held_pc;
	logic [31:0]      held_inst;
	logic             held_valid;

	logic [31:0]      live_inst;

	assign fetch_pc  = pc;
	assign live_inst = icache_hit ? icache_inst : `NOP_INST; // nop on a miss

	////////////////////////////////////////////////////////////////////////////
	// program counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset)
			pc <= '0;
		else if (redirect)
			pc <= redirect_pc;      // wins over the step
		else if (icache_hit && !hold)
			pc <= pc + `XLEN'd4;    // next word
	end

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	// a fill or a redirect during hold must not show through
	assign inst_pc    = hold ? held_pc    : pc;
	assign inst       = hold ? held_inst  : live_inst;
	assign inst_valid = hold ? held_valid : icache_hit;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_pc    <= '0;
			held_inst  <= `NOP_INST;
			held_valid <= 1'b0;
		end else begin
			held_pc    <= inst_pc;    // self loop while hold stays high
			held_inst  <= inst;
			held_valid <= inst_valid;
		end
	end

endmodule

// File: hdl/frontend_top.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module frontend_top import fetch_pkg::*; (
	input                    clock,
	input                    reset,
	input                    hold,
	input                    redirect,
	input  [`XLEN-1:0]       redirect_pc,
	input                    load_req,
	input  [`XLEN-1:0]       load_addr,
	input  mem_tag_t         mem_response, // grant tag
	input  mem_block_t       mem_data,
	input  mem_tag_t         mem_tag,      // reply tag

	output bus_cmd_t         mem_command,
	output logic [`XLEN-1:0] mem_addr,
	output logic [`XLEN-1:0] inst_pc,
	output logic [31:0]      inst,
	output logic             inst_valid,
	output logic             load_busy,
	output logic [63:0]      load_data,
	output logic             load_done
);

	// fetch <-> icache
	logic [`XLEN-1:0] fetch_pc;
	logic [31:0]      icache_inst;
	logic             icache_hit;

	// peers <-> arbiter
	bus_cmd_t         ic_command, dp_command;
	logic [`XLEN-1:0] ic_addr, dp_addr;
	mem_tag_t         ic_response, dp_response;

	////////////////////////////////////////////////////////////////////////////
	// fetch path
	////////////////////////////////////////////////////////////////////////////

	fetch_stage fetch_stage_0 (
		.clock(clock), .reset(reset),
		.hold(hold), .redirect(redirect), .redirect_pc(redirect_pc),
		.icache_inst(icache_inst), .icache_hit(icache_hit),
		.fetch_pc(fetch_pc),
		.inst_pc(inst_pc), .inst(inst), .inst_valid(inst_valid)
	);

	icache icache_0 (
		.clock(clock), .reset(reset), .fetch_pc(fetch_pc),
		.ic_response(ic_response), .mem_data(mem_data), .mem_tag(mem_tag),
		.icache_inst(icache_inst), .icache_hit(icache_hit),
		.ic_command(ic_command), .ic_addr(ic_addr)
	);

	////////////////////////////////////////////////////////////////////////////
	// data loads and bus sharing
	////////////////////////////////////////////////////////////////////////////

	data_load_port data_load_port_0 (
		.clock(clock), .reset(reset),
		.load_req(load_req), .load_addr(load_addr),
		.dp_response(dp_response), .mem_data(mem_data), .mem_tag(mem_tag),
		.dp_command(dp_command), .dp_addr(dp_addr),
		.load_busy(load_busy), .load_data(load_data), .load_done(load_done)
	);

	mem_arbiter mem_arbiter_0 (
		.ic_command(ic_command), .ic_addr(ic_addr),
		.dp_command(dp_command), .dp_addr(dp_addr), // data port first
		.mem_response(mem_response),
		.mem_command(mem_command), .mem_addr(mem_addr),
		.ic_response(ic_response), .dp_response(dp_response)
	);

endmodule

// File: hdl/icache.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache import fetch_pkg::*; (
	input                    clock,
	input                    reset,
	input  [`XLEN-1:0]       fetch_pc,    // from fetch stage
	input  mem_tag_t         ic_response, // grant tag, via the arbiter
	input  mem_block_t       mem_data,
	input  mem_tag_t         mem_tag,     // reply tag

	output logic [31:0]      icache_inst,
	output logic             icache_hit,
	output bus_cmd_t         ic_command,
	output logic [`XLEN-1:0] ic_addr
);

	localparam int BLK_W = `XLEN - `BLOCK_OFF_W;   // block address bits
	localparam int TAG_W = BLK_W - `ICACHE_IDX_W; // tag bits per line

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	logic [TAG_W-1:0]         line_tag  [`ICACHE_LINES];
	mem_block_t               line_data [`ICACHE_LINES];
	logic [`ICACHE_LINES-1:0] line_valid;

	// lookup fields of fetch_pc
	logic [BLK_W-1:0]         pc_block;
	logic [`ICACHE_IDX_W-1:0] pc_idx;
	logic [TAG_W-1:0]         pc_tag;
	mem_block_t               rd_block;

	// outstanding miss
	logic             wait_pend;  // granted, reply not yet seen
	mem_tag_t         wait_tag;   // tag memory gave us
	logic [BLK_W-1:0] wait_block; // block being fetched
	logic             same_wait;  // fetch_pc still on that block
	logic             grant;
	logic             fill;

	assign pc_block = fetch_pc[`XLEN-1:`BLOCK_OFF_W];
	assign pc_idx   = pc_block[`ICACHE_IDX_W-1:0];
	assign pc_tag   = pc_block[BLK_W-1:`ICACHE_IDX_W];

	////////////////////////////////////////////////////////////////////////////
	// hit path, combinational
	////////////////////////////////////////////////////////////////////////////

	assign rd_block    = line_data[pc_idx];
	assign icache_hit  = line_valid[pc_idx] && (line_tag[pc_idx] == pc_tag);
	assign icache_inst = rd_block.inst[fetch_pc[`BLOCK_OFF_W-1]]; // pc bit 2 picks the half

	////////////////////////////////////////////////////////////////////////////
	// miss path
	////////////////////////////////////////////////////////////////////////////

	assign same_wait = wait_pend && (wait_block == pc_block);

	// keep asking until granted, unless this block is already on its way
	// bus stays quiet while reset is held
	assign ic_command = (!reset && !icache_hit && !same_wait) ? bus_load : bus_none;
	assign ic_addr    = {pc_block, {`BLOCK_OFF_W{1'b0}}};

	assign grant = (ic_command == bus_load) && (ic_response != '0);
	assign fill  = wait_pend && (mem_tag == wait_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
			wait_pend  <= 1'b0;
		end else begin
			if (fill)
				line_valid[wait_block[`ICACHE_IDX_W-1:0]] <= 1'b1;
			if (grant)
				wait_pend <= 1'b1;  // new miss, may replace an abandoned one
			else if (fill || (wait_pend && !same_wait))
				wait_pend <= 1'b0;  // done, or pc moved away (redirect)
		end
	end

	// line contents and miss bookkeeping
	always_ff @(posedge clock) begin
		if (fill) begin
			line_tag[wait_block[`ICACHE_IDX_W-1:0]]  <= wait_block[BLK_W-1:`ICACHE_IDX_W];
			line_data[wait_block[`ICACHE_IDX_W-1:0]] <= mem_data;
		end
		if (grant) begin
			wait_tag   <= ic_response;
			wait_block <= pc_block;
		end
	end

endmodule

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

// fixed priority, data port ahead of the icache
module mem_arbiter import fetch_pkg::*; (
	input  bus_cmd_t         ic_command,   // icache request
	input  [`XLEN-1:0]       ic_addr,
	input  bus_cmd_t         dp_command,   // data load port request
	input  [`XLEN-1:0]       dp_addr,
	input  mem_tag_t         mem_response, // grant tag from memory

	output bus_cmd_t         mem_command,
	output logic [`XLEN-1:0] mem_addr,
	output mem_tag_t         ic_response,  // zero while the data port owns the bus
	output mem_tag_t         dp_response
);

	logic dp_grant; // data port owns the bus this cycle

	assign dp_grant = (dp_command == bus_load);

	always_comb begin
		if (dp_grant) begin
			mem_command = dp_command;
			mem_addr    = dp_addr;
			dp_response = mem_response;
			ic_response = '0;           // icache sees a refusal, retries next cycle
		end else begin
			mem_command = ic_command;   // may well be bus_none
			mem_addr    = ic_addr;
			dp_response = '0;
			ic_response = mem_response;
		end
	end

endmodule

// File: tests/frontend_props.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

// bound into frontend_top, watches the top level ports and the load port request
module frontend_props import fetch_pkg::*; (
	input             clock,
	input             reset,
	input             hold,
	input             redirect,
	input [`XLEN-1:0] redirect_pc,
	input             load_req,
	input [`XLEN-1:0] load_addr,
	input [`XLEN-1:0] inst_pc,
	input [31:0]      inst,
	input             inst_valid,
	input             load_busy,
	input [63:0]      load_data,
	input             load_done,
	input bus_cmd_t   mem_command,
	input [`XLEN-1:0] mem_addr,
	input bus_cmd_t   dp_command   // load port request, inside the top level
);

	localparam logic [31:0] word_key = 32'h5a5a0000; // word at A is A ^ key

	int fail_count = 0; // failed checks so far

	logic [`XLEN-1:0] last_pc;     // last pc shown with hold low
	logic             redir_pend;  // redirect since then
	logic [`XLEN-1:0] redir_pc;
	logic [`XLEN-1:0] load_q;      // load in flight
	logic [`XLEN-1:0] next_pc;
	logic [63:0]      load_expect;

	assign next_pc     = redir_pend ? redir_pc : last_pc + `XLEN'd4;
	assign load_expect = {(load_q + `XLEN'd4) ^ word_key, load_q ^ word_key}; // low word first

	always @(posedge clock) begin
		if (reset) begin
			redir_pend <= 1'b1;  // first fetch comes from the reset vector
			redir_pc   <= '0;
			last_pc    <= '0;
		end else begin
			if (redirect) begin
				redir_pend <= 1'b1;
				redir_pc   <= redirect_pc;
			end else if (inst_valid && !hold)
				redir_pend <= 1'b0;
			if (inst_valid && !hold)
				last_pc <= inst_pc;
		end
		if (load_req && !load_busy)
			load_q <= load_addr;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// outputs idle once reset has acted, bus idle as long as reset is held
	reset_idle: assert property (@(posedge clock) reset |=> !inst_valid && !load_busy
		&& !load_done && (!reset || mem_command == bus_none))
		else begin
			fail_count++;
			$error("** Error at %0t: not idle after reset, inst_valid = %b load_busy = %b",
				$time, inst_valid, load_busy);
			$error("** Error at %0t: load_done = %b mem_command = %0d, expected 0 and %0d",
				$time, load_done, mem_command, bus_none);
		end

	inst_image: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> inst == (inst_pc ^ word_key))
		else begin
			fail_count++;
			$error("** Error at %0t: inst = %h, expected %h", $time, inst, inst_pc ^ word_key);
		end

	pc_order: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !hold |-> inst_pc == next_pc)
		else begin
			fail_count++;
			$error("** Error at %0t: inst_pc = %h, expected %h", $time, inst_pc, next_pc);
		end

	hold_freeze: assert property (@(posedge clock) disable iff (reset)
		hold |-> $stable(inst_pc) && $stable(inst) && $stable(inst_valid))
		else begin
			fail_count++;
			$error("** Error at %0t: fetch outputs moved while hold was high", $time);
		end

	load_value: assert property (@(posedge clock) disable iff (reset)
		load_done |-> load_data == load_expect)
		else begin
			fail_count++;
			$error("** Error at %0t: load_data = %h, expected %h", $time, load_data, load_expect);
		end

	load_first: assert property (@(posedge clock) disable iff (reset)
		dp_command == bus_load |-> mem_command == bus_load
		&& mem_addr == {load_q[`XLEN-1:`BLOCK_OFF_W], {`BLOCK_OFF_W{1'b0}}})
		else begin
			fail_count++;
			$error("** Error at %0t: mem_addr = %h, expected %h", $time, mem_addr, load_q);
		end

endmodule

// File: tests/frontend_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module frontend_tb import fetch_pkg::*; ();

	logic             clock;
	logic             reset;
	logic             hold;
	logic             redirect;
	logic [`XLEN-1:0] redirect_pc;
	logic             load_req;
	logic [`XLEN-1:0] load_addr;
	mem_tag_t         mem_response;
	mem_block_t       mem_data;
	mem_tag_t         mem_tag;
	bus_cmd_t         mem_command;
	logic [`XLEN-1:0] mem_addr;
	logic [`XLEN-1:0] inst_pc;
	logic [31:0]      inst;
	logic             inst_valid;
	logic             load_busy;
	logic [63:0]      load_data;
	logic             load_done;

	localparam int miss_cost  = 20;  // worst bus transfer, refusals included
	localparam int bus_events = 100; // misses and loads over all tests
	localparam int max_cycles = 2 * miss_cost * bus_events;

	int cycle_count     = 0;
	int tests_run       = 0;
	int failures_before = 0;

	frontend_top frontend_top_inst (.*);
	mem_model mem_model_0 (.*);

	bind frontend_top frontend_props props_0 (
		.clock(clock), .reset(reset), .hold(hold), .redirect(redirect),
		.redirect_pc(redirect_pc), .load_req(load_req), .load_addr(load_addr),
		.inst_pc(inst_pc), .inst(inst), .inst_valid(inst_valid),
		.load_busy(load_busy), .load_data(load_data), .load_done(load_done),
		.mem_command(mem_command), .mem_addr(mem_addr), .dp_command(dp_command)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// watchdog
	initial begin
		while (cycle_count < max_cycles) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: run did not end within %0d cycles", max_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers, all return 1 ns after a rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic count_fetches(input int n); // valid fetches with hold low
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clock);
			if (inst_valid && !hold)
				seen++;
		end
		next_cycle();
	endtask

	task automatic pulse_redirect(input logic [`XLEN-1:0] target);
		redirect    = 1'b1;
		redirect_pc = target;
		next_cycle();
		redirect = 1'b0;
	endtask

	task automatic issue_load(input logic [`XLEN-1:0] addr);
		while (load_busy || inst_valid) // wait for a fetch miss
			next_cycle();
		load_req  = 1'b1;
		load_addr = addr;
		next_cycle();
		load_req = 1'b0;
		while (!load_done)
			next_cycle();
	endtask

	task automatic report_test(input string name);
		int now_failed;
		now_failed = frontend_top_inst.props_0.fail_count;
		tests_run++;
		$display("test %0d %s: %s, %0d assertion failures", tests_run, name,
			(now_failed == failures_before) ? "passed" : "failed",
			now_failed - failures_before);
		failures_before = now_failed;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int i;
		reset       = 1'b1;
		hold        = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		load_req    = 1'b0;
		load_addr   = '0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		next_cycle();
		report_test("reset state");

		count_fetches(64);              // 32 blocks, a miss then a hit each
		report_test("straight-line fetch");

		pulse_redirect(`XLEN'h40);      // lands in cached lines
		count_fetches(6);
		pulse_redirect(`XLEN'h1000);    // cold region
		count_fetches(8);
		report_test("redirect");

		hold = 1'b1;
		repeat (3) next_cycle();
		pulse_redirect(`XLEN'h80);      // taken under hold
		repeat (3) next_cycle();
		hold = 1'b0;
		count_fetches(8);
		report_test("hold");

		pulse_redirect(`XLEN'h2000);
		for (i = 0; i < 6; i++)
			issue_load(`XLEN'h3000 + i * 8);
		report_test("loads while fetch misses");

		for (i = 0; i < 4; i++) begin
			pulse_redirect(`XLEN'h4000 + i * 256); // icache asks as the load goes out
			issue_load(`XLEN'h5000 + i * 8);
		end
		count_fetches(4);
		report_test("bus sharing");

		failures_before = frontend_top_inst.props_0.fail_count;
		$display("%0d tests, %0d assertion failures, %0d cycles", tests_run,
			failures_before, cycle_count);
		if (failures_before == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: tests/mem_model.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

// tagged memory responder, random grants, replies in order
module mem_model import fetch_pkg::*; (
	input              clock,
	input              reset,
	input  bus_cmd_t   mem_command,
	input  [`XLEN-1:0] mem_addr,
	output mem_tag_t   mem_response,
	output mem_block_t mem_data,
	output mem_tag_t   mem_tag
);

	localparam logic [31:0] word_key = 32'h5a5a0000;

	logic     accept;   // grant a load this cycle
	mem_tag_t next_tag; // 1 to 15 in turn

	// replies in flight, oldest first
	mem_tag_t         q_tag [$];
	logic [`XLEN-1:0] q_addr [$];
	int               q_due [$];

	assign mem_response = (mem_command == bus_load && accept) ? next_tag : '0;

	initial begin
		logic             in_reset;
		logic             taken;
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] a;
		logic [31:0]      rnd;
		int               cycle;
		int               due;
		int               last_due;
		rnd      = $urandom(32'hb595); // seed once for the run
		cycle    = 0;
		last_due = 0;
		accept   = 1'b0;
		next_tag = 4'd1;
		mem_tag  = '0;
		mem_data = '0;
		forever begin
			@(posedge clock);
			in_reset = reset;                 // bus as the DUT sees it at this edge
			taken    = (mem_response != '0);
			addr     = {mem_addr[`XLEN-1:`BLOCK_OFF_W], {`BLOCK_OFF_W{1'b0}}};
			cycle++;
			#1;
			if (in_reset) begin
				q_tag.delete();
				q_addr.delete();
				q_due.delete();
				next_tag = 4'd1;
			end else if (taken) begin
				rnd = $urandom;
				due = cycle + 4 + int'(rnd % 5); // 4 to 8 cycles
				if (due <= last_due)
					due = last_due + 1;          // one reply per cycle
				last_due = due;
				q_tag.push_back(next_tag);
				q_addr.push_back(addr);
				q_due.push_back(due);
				next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
			// reply bus for the coming cycle
			mem_tag  = '0;
			mem_data = '0;
			if (q_due.size() > 0 && q_due[0] <= cycle + 1) begin
				due      = q_due.pop_front();
				a        = q_addr.pop_front();
				mem_tag  = q_tag.pop_front();
				mem_data = {(a + `XLEN'd4) ^ word_key, a ^ word_key};
			end
			rnd    = $urandom;
			accept = !in_reset && (rnd[1:0] != 2'b00); // 3 in 4
		end
	end

endmodule
